/* hw/fu_defs.svh */
`ifndef FU_DEFS_SVH
`define FU_DEFS_SVH

// General purpose register width
`define GPR_SIZE 64

// Width of a reorder buffer index
`define ROB_IDX_SIZE 5

// Data memory depth in doublewords
`define DMEM_WORDS 32

`endif

/* hw/fu_pkg.sv */
`default_nettype none

`include "fu_defs.svh"

package fu_pkg;

  // Operations understood by the functional units
  typedef enum logic [3:0] {
    PLUS  = 4'd0,
    MINUS = 4'd1,
    ORN   = 4'd2,
    OR    = 4'd3,
    EOR   = 4'd4,
    AND   = 4'd5,
    CSEL  = 4'd6,
    CSINC = 4'd7,
    CSINV = 4'd8,
    CSNEG = 4'd9,
    LDUR  = 4'd10,
    STUR  = 4'd11
  } fu_op_t;

  // ARM condition codes in their architectural encoding
  typedef enum logic [3:0] {
    EQ = 4'd0,
    NE = 4'd1,
    CS = 4'd2,
    CC = 4'd3,
    MI = 4'd4,
    PL = 4'd5,
    VS = 4'd6,
    VC = 4'd7,
    HI = 4'd8,
    LS = 4'd9,
    GE = 4'd10,
    LT = 4'd11,
    GT = 4'd12,
    LE = 4'd13,
    AL = 4'd14,
    NV = 4'd15
  } cond_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // One operation leaving a reservation station
  typedef struct packed {
    fu_op_t                   op;
    logic [`GPR_SIZE-1:0]     val_a;
    logic [`GPR_SIZE-1:0]     val_b;
    logic [`ROB_IDX_SIZE-1:0] rob_idx;
    logic                     set_nzcv;
    nzcv_t                    nzcv;
    cond_t                    cond;
  } issue_t;

  // One completed operation heading for the ROB
  typedef struct packed {
    logic [`ROB_IDX_SIZE-1:0] rob_idx;
    logic [`GPR_SIZE-1:0]     value;
    logic                     set_nzcv;
    nzcv_t                    nzcv;
    logic                     cond_holds;
  } result_t;

endpackage

`default_nettype wire

/* hw/cond_eval.sv */
`timescale 1ns/1ps
`default_nettype none

module cond_eval (
  input  fu_pkg::cond_t cond,
  input  fu_pkg::nzcv_t nzcv,
  output logic          holds
);

  logic base;

  // Upper three bits pick the test, the low bit inverts it
  always_comb begin
    case (cond[3:1])
      // EQ and NE
      3'b000: base = nzcv.z;
      // CS and CC
      3'b001: base = nzcv.c;
      // MI and PL
      3'b010: base = nzcv.n;
      // VS and VC
      3'b011: base = nzcv.v;
      // HI and LS
      3'b100: base = nzcv.c & ~nzcv.z;
      // GE and LT
      3'b101: base = (nzcv.n == nzcv.v);
      // GT and LE
      3'b110: base = (nzcv.n == nzcv.v) & ~nzcv.z;
      // AL and NV
      default: base = 1'b1;
    endcase
  end

  // NV is treated as always, so it is the one odd code left uninverted
  assign holds = (cond[0] && (cond != fu_pkg::NV)) ? ~base : base;

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fu_defs.svh"

module alu (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  fu_pkg::issue_t  issue,
  output logic            done,
  output fu_pkg::result_t result
);

  localparam int MSB = `GPR_SIZE - 1;

  fu_pkg::issue_t       op_q;
  logic                 cond_ok;
  logic [`GPR_SIZE:0]   sum;
  logic [`GPR_SIZE:0]   diff;
  logic [`GPR_SIZE-1:0] value;
  fu_pkg::nzcv_t        flags;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

  // Operation is latched on issue, result comes out of it the cycle after
  always_ff @(posedge clk) begin
    if (start) begin
      op_q <= issue;
    end
  end

  cond_eval cond_eval_i (
    .cond  (op_q.cond),
    .nzcv  (op_q.nzcv),
    .holds (cond_ok)
  );

  // Extra top bit carries out of the add and borrows out of the subtract
  assign sum  = {1'b0, op_q.val_a} + {1'b0, op_q.val_b};
  assign diff = {1'b0, op_q.val_a} - {1'b0, op_q.val_b};

  always_comb begin
    case (op_q.op)
      fu_pkg::PLUS:  value = sum[MSB:0];
      fu_pkg::MINUS: value = diff[MSB:0];
      fu_pkg::ORN:   value = op_q.val_a | ~op_q.val_b;
      fu_pkg::OR:    value = op_q.val_a | op_q.val_b;
      fu_pkg::EOR:   value = op_q.val_a ^ op_q.val_b;
      fu_pkg::AND:   value = op_q.val_a & op_q.val_b;
      fu_pkg::CSEL:  value = cond_ok ? op_q.val_a : op_q.val_b;
      fu_pkg::CSINC: value = cond_ok ? op_q.val_a : op_q.val_b + `GPR_SIZE'(1);
      fu_pkg::CSINV: value = cond_ok ? op_q.val_a : ~op_q.val_b;
      fu_pkg::CSNEG: value = cond_ok ? op_q.val_a : -op_q.val_b;
      default:       value = '0;
    endcase
  end

  always_comb begin
    flags = op_q.nzcv;
    if (op_q.set_nzcv) begin
      flags.n = value[MSB];
      flags.z = (value == '0);
      // Logic ops and selects clear C and V
      flags.c = 1'b0;
      flags.v = 1'b0;
      if (op_q.op == fu_pkg::PLUS) begin
        flags.c = sum[`GPR_SIZE];
        flags.v = (op_q.val_a[MSB] == op_q.val_b[MSB]) && (value[MSB] != op_q.val_a[MSB]);
      end else if (op_q.op == fu_pkg::MINUS) begin
        // Carry set means no borrow
        flags.c = ~diff[`GPR_SIZE];
        flags.v = (op_q.val_a[MSB] != op_q.val_b[MSB]) && (value[MSB] != op_q.val_a[MSB]);
      end
    end
  end

  always_comb begin
    result.rob_idx    = op_q.rob_idx;
    result.value      = value;
    result.set_nzcv   = op_q.set_nzcv;
    result.nzcv       = flags;
    result.cond_holds = cond_ok;
  end

  // Memory ops belong to the load/store unit, never to this one
  a_no_mem_op: assert property (
    @(posedge clk) disable iff (!rst_n)
    start |-> !(issue.op inside {fu_pkg::LDUR, fu_pkg::STUR})
  );

endmodule

`default_nettype wire

/* hw/lsu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fu_defs.svh"

module lsu (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  fu_pkg::issue_t  issue,
  output logic            done,
  output fu_pkg::result_t result
);

  localparam int IDX_W = $clog2(`DMEM_WORDS);

  logic [`GPR_SIZE-1:0]     mem [`DMEM_WORDS];
  logic [IDX_W-1:0]         idx;
  logic                     is_store;
  logic [`GPR_SIZE-1:0]     rdata;
  logic [`ROB_IDX_SIZE-1:0] rob_idx_q;
  fu_pkg::nzcv_t            nzcv_q;

  // Doubleword index, byte offset bits are dropped
  assign idx      = issue.val_a[3 +: IDX_W];
  assign is_store = (issue.op == fu_pkg::STUR);

  // Memory starts out zeroed after every reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (start && is_store) begin
      mem[idx] <= issue.val_b;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

  // A store hands back the data it wrote
  always_ff @(posedge clk) begin
    if (start) begin
      rdata     <= is_store ? issue.val_b : mem[idx];
      rob_idx_q <= issue.rob_idx;
      nzcv_q    <= issue.nzcv;
    end
  end

  always_comb begin
    result.rob_idx    = rob_idx_q;
    result.value      = rdata;
    result.set_nzcv   = 1'b0;
    result.nzcv       = nzcv_q;
    result.cond_holds = 1'b0;
  end

  a_mem_op_only: assert property (
    @(posedge clk) disable iff (!rst_n)
    start |-> (issue.op inside {fu_pkg::LDUR, fu_pkg::STUR})
  );

endmodule

`default_nettype wire

/* hw/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            alu_done,
  input  fu_pkg::result_t alu_result,
  input  logic            ls_done,
  input  fu_pkg::result_t ls_result,
  output logic            ls_ready,
  output logic            result_valid,
  output fu_pkg::result_t result
);

  logic            buf_valid;
  fu_pkg::result_t buf_q;
  logic            buf_fill;
  logic            sel_buf;

  // The ALU cannot be stalled, so its result always takes the port and
  // the held load/store result goes out in the first cycle the ALU is idle
  assign sel_buf  = buf_valid && !alu_done;
  assign buf_fill = ls_done && alu_done;

  // Blocks new loads/stores while the buffer is busy or filling
  assign ls_ready = !buf_valid && !buf_fill;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      buf_valid <= 1'b0;
    end else if (buf_fill) begin
      buf_valid <= 1'b1;
    end else if (sel_buf) begin
      buf_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (buf_fill) begin
      buf_q <= ls_result;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= alu_done || buf_valid || ls_done;
    end
  end

  always_ff @(posedge clk) begin
    if (alu_done) begin
      result <= alu_result;
    end else if (buf_valid) begin
      result <= buf_q;
    end else if (ls_done) begin
      result <= ls_result;
    end
  end

  a_no_ls_over_buf: assert property (
    @(posedge clk) disable iff (!rst_n)
    ls_done |-> !buf_valid
  );

  // LSU latency is one cycle, so a refused start cannot complete
  a_ls_ready_respected: assert property (
    @(posedge clk) disable iff (!rst_n)
    !ls_ready |=> !ls_done
  );

endmodule

`default_nettype wire

/* hw/func_units.sv */
`timescale 1ns/1ps
`default_nettype none

module func_units (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            alu_start,
  input  fu_pkg::issue_t  alu_issue,
  input  logic            ls_start,
  input  fu_pkg::issue_t  ls_issue,
  output logic            ls_ready,
  output logic            result_valid,
  output fu_pkg::result_t result
);

  logic            alu_done;
  fu_pkg::result_t alu_result;
  logic            ls_done;
  fu_pkg::result_t ls_result;

  alu alu_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (alu_start),
    .issue  (alu_issue),
    .done   (alu_done),
    .result (alu_result)
  );

  lsu lsu_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (ls_start),
    .issue  (ls_issue),
    .done   (ls_done),
    .result (ls_result)
  );

  // Single writeback port shared by both units
  wb_arbiter wb_arbiter_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .alu_done     (alu_done),
    .alu_result   (alu_result),
    .ls_done      (ls_done),
    .ls_result    (ls_result),
    .ls_ready     (ls_ready),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

/* verif/fu_ref_model.svh */
// Expected results of the execution units, computed at issue time

localparam logic [`GPR_SIZE-1:0] REF_ONE = `GPR_SIZE'(1);

// Memory image, updated in issue order
logic [`GPR_SIZE-1:0] ref_mem [`DMEM_WORDS];

function automatic logic ref_cond(fu_pkg::cond_t cond, fu_pkg::nzcv_t f);
  case (cond)
    fu_pkg::EQ: return f.z;
    fu_pkg::NE: return !f.z;
    fu_pkg::CS: return f.c;
    fu_pkg::CC: return !f.c;
    fu_pkg::MI: return f.n;
    fu_pkg::PL: return !f.n;
    fu_pkg::VS: return f.v;
    fu_pkg::VC: return !f.v;
    fu_pkg::HI: return f.c && !f.z;
    fu_pkg::LS: return !f.c || f.z;
    fu_pkg::GE: return f.n == f.v;
    fu_pkg::LT: return f.n != f.v;
    fu_pkg::GT: return !f.z && (f.n == f.v);
    fu_pkg::LE: return f.z || (f.n != f.v);
    // AL, and NV which acts the same
    default: return 1'b1;
  endcase
endfunction

function automatic fu_pkg::result_t ref_alu(fu_pkg::issue_t iss);
  fu_pkg::result_t      res;
  logic [`GPR_SIZE-1:0] a;
  logic [`GPR_SIZE-1:0] b;
  logic [`GPR_SIZE-1:0] v;
  logic [`GPR_SIZE:0]   wide;
  logic                 holds;
  a = iss.val_a;
  b = iss.val_b;
  holds = ref_cond(iss.cond, iss.nzcv);
  case (iss.op)
    fu_pkg::PLUS:  v = a + b;
    fu_pkg::MINUS: v = a - b;
    fu_pkg::ORN:   v = a | ~b;
    fu_pkg::OR:    v = a | b;
    fu_pkg::EOR:   v = a ^ b;
    fu_pkg::AND:   v = a & b;
    fu_pkg::CSEL:  v = holds ? a : b;
    fu_pkg::CSINC: v = holds ? a : b + REF_ONE;
    fu_pkg::CSINV: v = holds ? a : ~b;
    fu_pkg::CSNEG: v = holds ? a : ~b + REF_ONE;
    default:       v = '0;
  endcase
  res.rob_idx    = iss.rob_idx;
  res.value      = v;
  res.set_nzcv   = iss.set_nzcv;
  res.cond_holds = holds;
  res.nzcv       = iss.nzcv;
  if (iss.set_nzcv) begin
    res.nzcv.n = v[`GPR_SIZE-1];
    res.nzcv.z = (v == '0);
    res.nzcv.c = 1'b0;
    res.nzcv.v = 1'b0;
    // Signed overflow shows as a sign-extended sum whose top two bits differ
    if (iss.op == fu_pkg::PLUS) begin
      wide = {a[`GPR_SIZE-1], a} + {b[`GPR_SIZE-1], b};
      res.nzcv.c = (v < a);
      res.nzcv.v = (wide[`GPR_SIZE] != wide[`GPR_SIZE-1]);
    end else if (iss.op == fu_pkg::MINUS) begin
      wide = {a[`GPR_SIZE-1], a} - {b[`GPR_SIZE-1], b};
      res.nzcv.c = (a >= b);
      res.nzcv.v = (wide[`GPR_SIZE] != wide[`GPR_SIZE-1]);
    end
  end
  return res;
endfunction

function automatic fu_pkg::result_t ref_lsu(fu_pkg::issue_t iss);
  fu_pkg::result_t res;
  int              idx;
  idx = int'((iss.val_a >> 3) % `GPR_SIZE'(`DMEM_WORDS));
  res.rob_idx    = iss.rob_idx;
  res.set_nzcv   = 1'b0;
  res.nzcv       = iss.nzcv;
  res.cond_holds = 1'b0;
  if (iss.op == fu_pkg::STUR) begin
    ref_mem[idx] = iss.val_b;
  end
  res.value = ref_mem[idx];
  return res;
endfunction

/* verif/tb_func_units.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fu_defs.svh"

module tb_func_units;

  localparam int N_RANDOM = 200;
  // Zero loads, selects, logic and arithmetic, stores and loads, then the random mix
  localparam int N_ISSUES = 8 + 64 + 24 + 32 + N_RANDOM;
  localparam int TIMEOUT_CYCLES = N_ISSUES * 4 + 50;
  localparam int SLOTS = 1 << `ROB_IDX_SIZE;

  logic            clk;
  logic            rst_n;
  logic            alu_start;
  fu_pkg::issue_t  alu_issue;
  logic            ls_start;
  fu_pkg::issue_t  ls_issue;
  logic            ls_ready;
  logic            result_valid;
  fu_pkg::result_t result;

  // Scoreboard indexed by rob_idx
  fu_pkg::result_t expected [SLOTS];
  logic            in_flight [SLOTS];
  logic            on_alu [SLOTS];
  logic            exact [SLOTS];
  int              issued_at [SLOTS];
  int              alu_order [$];
  int              ls_order [$];
  int              outstanding;
  int              next_idx;
  int              cycle_count;
  logic [31:0]     lcg_state;
  logic            ls_solo;
  // Writeback buffer occupancy rebuilt from the strobes
  logic            m_alu_done;
  logic            m_ls_done;
  logic            m_buf;

  `include "fu_ref_model.svh"

  func_units func_units_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .alu_start    (alu_start),
    .alu_issue    (alu_issue),
    .ls_start     (ls_start),
    .ls_issue     (ls_issue),
    .ls_ready     (ls_ready),
    .result_valid (result_valid),
    .result       (result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
        fail_now($sformatf("Timeout, the test did not end within %0d cycles", TIMEOUT_CYCLES));
      end
    end
  end

  function automatic void fail_now(string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1, "Stopped at the first error");
  endfunction

  function automatic void value_error(string msg);
    fail_now($sformatf("[FAIL] time %0d ns: %s", $time, msg));
  endfunction

  function automatic int rand_below(int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // High bits of the LCG are the well mixed ones
    return int'(lcg_state[31:16]) % n;
  endfunction

  function automatic logic [`GPR_SIZE-1:0] rand_word();
    case (rand_below(6))
      0: return '0;
      1: return '1;
      2: return {1'b1, {(`GPR_SIZE-1){1'b0}}};
      3: return {1'b0, {(`GPR_SIZE-1){1'b1}}};
      default: return {16'(rand_below(65536)), 16'(rand_below(65536)),
                       16'(rand_below(65536)), 16'(rand_below(65536))};
    endcase
  endfunction

  function automatic fu_pkg::issue_t rand_issue(fu_pkg::fu_op_t op, int span);
    fu_pkg::issue_t iss;
    iss          = '0;
    iss.op       = op;
    iss.val_a    = rand_word();
    iss.val_b    = rand_word();
    iss.set_nzcv = (rand_below(2) == 1);
    iss.nzcv     = fu_pkg::nzcv_t'(4'(rand_below(16)));
    iss.cond     = fu_pkg::cond_t'(4'(rand_below(16)));
    // Memory address is a doubleword below span plus random byte offset bits
    if (span > 0) begin
      iss.val_a      = '0;
      iss.val_a[7:3] = 5'(rand_below(span));
      iss.val_a[2:0] = 3'(rand_below(8));
    end
    return iss;
  endfunction

  task automatic book(inout fu_pkg::issue_t iss, input logic is_alu);
    for (int k = 0; k < SLOTS && in_flight[next_idx]; k++) begin
      next_idx = (next_idx + 1) % SLOTS;
    end
    assert (!in_flight[next_idx]) else fail_now("No free ROB index left to hand out");
    iss.rob_idx = `ROB_IDX_SIZE'(next_idx);
    if (is_alu) begin
      expected[next_idx] = ref_alu(iss);
      alu_order.push_back(next_idx);
    end else begin
      expected[next_idx] = ref_lsu(iss);
      ls_order.push_back(next_idx);
    end
    in_flight[next_idx] = 1'b1;
    on_alu[next_idx]    = is_alu;
    exact[next_idx]     = is_alu || ls_solo;
    issued_at[next_idx] = cycle_count;
    outstanding++;
    next_idx = (next_idx + 1) % SLOTS;
  endtask

  task automatic drive(logic a_go, fu_pkg::issue_t a_iss, logic l_go, fu_pkg::issue_t l_iss);
    fu_pkg::issue_t a;
    fu_pkg::issue_t l;
    a = a_iss;
    l = l_iss;
    if (a_go) begin
      book(a, 1'b1);
    end
    if (l_go) begin
      book(l, 1'b0);
    end
    alu_start = a_go;
    alu_issue = a;
    ls_start  = l_go;
    ls_issue  = l;
  endtask

  // Falling edge view of the posedge that just passed
  task automatic observe();
    int idx;
    int lat;
    @(negedge clk);
    // Buffer fills on a collision and drains in the first cycle without an ALU result
    if (m_alu_done && m_ls_done) begin
      m_buf = 1'b1;
    end else if (!m_alu_done) begin
      m_buf = 1'b0;
    end
    m_alu_done = alu_start;
    m_ls_done  = ls_start;
    assert (ls_ready == !(m_buf || (m_alu_done && m_ls_done))) else
      value_error($sformatf("ls_ready is %b with buffer model %b", ls_ready, m_buf));
    if (result_valid) begin
      idx = int'(result.rob_idx);
      lat = cycle_count - issued_at[idx];
      assert (in_flight[idx]) else value_error($sformatf("rob_idx %0d not in flight", idx));
      assert (result == expected[idx]) else
        value_error($sformatf("rob_idx %0d gave %h, expected %h", idx, result, expected[idx]));
      assert (lat == 2 || (!exact[idx] && lat > 2)) else
        value_error($sformatf("rob_idx %0d took %0d cycles", idx, lat));
      if (on_alu[idx]) begin
        assert (alu_order[0] == idx) else value_error("ALU result out of issue order");
        void'(alu_order.pop_front());
      end else begin
        assert (ls_order[0] == idx) else value_error("Load/store result out of issue order");
        void'(ls_order.pop_front());
      end
      in_flight[idx] = 1'b0;
      outstanding--;
    end
  endtask

  task automatic send_alu(fu_pkg::issue_t iss);
    observe();
    drive(1'b1, iss, 1'b0, '0);
  endtask

  task automatic send_ls(fu_pkg::issue_t iss);
    observe();
    while (!ls_ready) begin
      drive(1'b0, '0, 1'b0, '0);
      observe();
    end
    drive(1'b0, '0, 1'b1, iss);
  endtask

  initial begin
    fu_pkg::issue_t a_iss;
    fu_pkg::issue_t l_iss;
    logic           a_go;
    logic           l_go;
    int             issued;
    rst_n       = 1'b0;
    alu_start   = 1'b0;
    alu_issue   = '0;
    ls_start    = 1'b0;
    ls_issue    = '0;
    lcg_state   = 32'd30;
    outstanding = 0;
    next_idx    = 0;
    ls_solo     = 1'b1;
    m_alu_done  = 1'b0;
    m_ls_done   = 1'b0;
    m_buf       = 1'b0;
    for (int i = 0; i < SLOTS; i++) begin
      in_flight[i] = 1'b0;
    end
    for (int i = 0; i < `DMEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    observe();
    assert (!result_valid && ls_ready) else value_error("Outputs not idle after reset");
    drive(1'b0, '0, 1'b0, '0);
    repeat (8) send_ls(rand_issue(fu_pkg::LDUR, 32));

    // Every select flavour under every condition
    for (int c = 0; c < 16; c++) begin
      for (int k = 0; k < 4; k++) begin
        a_iss      = rand_issue(fu_pkg::fu_op_t'(4'(int'(fu_pkg::CSEL) + k)), 0);
        a_iss.cond = fu_pkg::cond_t'(4'(c));
        send_alu(a_iss);
      end
    end
    repeat (24) send_alu(rand_issue(fu_pkg::fu_op_t'(4'(rand_below(6))), 0));

    // Few doublewords, so loads hit earlier stores and alias on the offset bits
    repeat (16) send_ls(rand_issue(fu_pkg::STUR, 8));
    repeat (16) send_ls(rand_issue(fu_pkg::LDUR, 8));

    // Dense mixed issue where loads and stores may wait behind the ALU
    ls_solo = 1'b0;
    issued  = 0;
    while (issued < N_RANDOM) begin
      observe();
      a_go  = (rand_below(8) < 5);
      l_go  = ls_ready && (rand_below(2) == 1) && (issued + int'(a_go) < N_RANDOM);
      a_iss = rand_issue(fu_pkg::fu_op_t'(4'(rand_below(10))), 0);
      l_iss = rand_issue((rand_below(2) == 1) ? fu_pkg::STUR : fu_pkg::LDUR, 32);
      drive(a_go, a_iss, l_go, l_iss);
      issued += int'(a_go) + int'(l_go);
    end

    while (outstanding > 0) begin
      observe();
      drive(1'b0, '0, 1'b0, '0);
    end
    repeat (3) begin
      observe();
      drive(1'b0, '0, 1'b0, '0);
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* fu_subsys.f */
+incdir+hw
+incdir+verif
hw/fu_pkg.sv
hw/cond_eval.sv
hw/alu.sv
hw/lsu.sv
hw/wb_arbiter.sv
hw/func_units.sv
verif/tb_func_units.sv

/* Makefile */
TOP     ?= tb_func_units
FLIST   ?= fu_subsys.f
OBJ_DIR ?= obj_dir
VFLAGS  ?= --binary --timing --assert

.PHONY: sim clean

sim:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
